/* source/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Address and instruction width of the fetch path
`define FETCH_ADDR_W 32

// Granted requests the memory port can keep track of
`define FETCH_MAX_OUTST 2

// PC after reset
`define FETCH_BOOT_ADDR 32'h0000_0000

`endif

/* source/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

  // Format of the instruction currently issued by the prefetch buffer
  typedef enum logic [1:0] {
    FULL_ALIGNED,  // 32-bit instruction on a word boundary
    C_ALIGNED,     // Compressed in the low halfword
    C_MISALIGNED   // Halfword at PC[1] set
  } instr_fmt_e;

  // Item passed from prefetch buffer to expander
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] instr;       // Upper half zero when compressed
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     compressed;  // Real RVC encoding
    logic                     illegal;     // 32-bit encoding at halfword address
  } fetch_item_t;

  // Expander classification of a compressed instruction
  typedef enum logic [2:0] {
    RVC_ADDI,   // Also covers C.NOP
    RVC_LI,
    RVC_MV,
    RVC_ADD,
    RVC_OTHER   // Not expanded
  } rvc_op_e;

endpackage

/* source/fetch_ifs.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

////////////////////////////////////////
// Request path to instruction memory
////////////////////////////////////////

interface instr_mem_if;
  logic                     req;     // Held until gnt
  logic [`FETCH_ADDR_W-1:0] addr;    // Word aligned
  logic                     flush;   // Branch pulse, outstanding requests go stale
  logic                     gnt;
  logic [`FETCH_ADDR_W-1:0] rdata;
  logic                     rvalid;  // Only for live requests

  // Prefetch buffer side
  modport master (
    output req, addr, flush,
    input  gnt, rdata, rvalid
  );

  // Memory port side
  modport slave (
    input  req, addr, flush,
    output gnt, rdata, rvalid
  );
endinterface

////////////////////////////////////////
// Buffer to expander handshake
////////////////////////////////////////

interface fetch_out_if;
  logic                   valid;
  logic                   ready;
  fetch_pkg::fetch_item_t item;   // Stable while valid and not ready

  modport source (
    output valid, item,
    input  ready
  );

  modport sink (
    input  valid, item,
    output ready
  );
endinterface

/* source/fetch_mem_port.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_mem_port (
  input  logic                     clk,
  input  logic                     rst_n,
  instr_mem_if.slave               mem,
  output logic                     instr_req_o,
  input  logic                     instr_gnt_i,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input  logic [`FETCH_ADDR_W-1:0] instr_rdata_i,
  input  logic                     instr_rvalid_i,
  output logic                     outst_o
);
  localparam int CNT_W = $clog2(`FETCH_MAX_OUTST + 1);
  localparam logic [CNT_W:0] MAX_CNT = `FETCH_MAX_OUTST;

  logic [CNT_W-1:0] live_q, live_d;    // Granted, response still wanted
  logic [CNT_W-1:0] stale_q, stale_d;  // Granted, cancelled by a branch
  logic [CNT_W:0]   total;
  logic             full;
  logic             grant;
  logic             rsp_stale;

  assign total = {1'b0, live_q} + {1'b0, stale_q};
  assign full  = (total >= MAX_CNT);   // No room to track another grant

  // Request goes straight out unless the tracker is full
  assign instr_req_o  = mem.req & ~full;
  assign instr_addr_o = mem.addr;
  assign grant        = instr_req_o & instr_gnt_i;
  assign mem.gnt      = grant;

  // In-order responses, so stale ones are always the oldest
  assign rsp_stale  = (stale_q != '0);
  assign mem.rvalid = instr_rvalid_i & ~rsp_stale;  // Swallow stale data
  assign mem.rdata  = instr_rdata_i;
  assign outst_o    = (total != '0);

  always_comb begin
    live_d  = live_q;
    stale_d = stale_q;
    // Retire the oldest request first
    if (instr_rvalid_i) begin
      if (rsp_stale)
        stale_d = stale_d - 1'b1;
      else
        live_d = live_d - 1'b1;
    end
    // Branch turns everything still live into stale
    if (mem.flush) begin
      stale_d = stale_d + live_d;
      live_d  = '0;
    end
    // A grant in the flush cycle belongs to the new target
    if (grant)
      live_d = live_d + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_q  <= '0;
      stale_q <= '0;
    end else begin
      live_q  <= live_d;
      stale_q <= stale_d;
    end
  end

endmodule

/* source/prefetch_buffer.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module prefetch_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  instr_mem_if.master              mem,
  fetch_out_if.source              out,
  output logic                     busy_o
);
  localparam int AW = `FETCH_ADDR_W;
  localparam logic [AW-1:0] STEP_WORD = 4;
  localparam logic [AW-1:0] STEP_HALF = 2;

  typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID} state_e;

  state_e                 state_q, state_d;
  logic [AW-1:0]          fetch_addr_q, fetch_addr_d;  // PC of the item being issued
  logic [AW-1:0]          held_word_q, held_word_d;    // Word kept on stall or for high half
  logic                   held_valid_q, held_valid_d;

  fetch_pkg::instr_fmt_e  fmt;
  fetch_pkg::fetch_item_t item;
  logic [AW-1:0]          word_mux;
  logic [AW-1:0]          pc_next;
  logic [15:0]            half;
  logic                   misaligned;
  logic                   word_avail;

  assign misaligned = fetch_addr_q[1];
  assign word_mux   = held_valid_q ? held_word_q : mem.rdata;
  assign word_avail = held_valid_q | mem.rvalid;
  assign half       = misaligned ? word_mux[31:16] : word_mux[15:0];

  // Decide what sits at the current PC
  always_comb begin
    if (misaligned)
      fmt = fetch_pkg::C_MISALIGNED;
    else if (word_mux[1:0] != 2'b11)
      fmt = fetch_pkg::C_ALIGNED;
    else
      fmt = fetch_pkg::FULL_ALIGNED;
  end

  // The one PC adder
  always_comb begin
    unique case (fmt)
      fetch_pkg::FULL_ALIGNED: pc_next = fetch_addr_q + STEP_WORD;
      default:                 pc_next = fetch_addr_q + STEP_HALF;  // Also after illegal
    endcase
  end

  // Item toward the expander
  always_comb begin
    item.pc         = fetch_addr_q;
    item.compressed = (fmt != fetch_pkg::FULL_ALIGNED) && (half[1:0] != 2'b11);
    item.illegal    = (fmt == fetch_pkg::C_MISALIGNED) && (half[1:0] == 2'b11);
    if (fmt == fetch_pkg::FULL_ALIGNED)
      item.instr = word_mux;
    else
      item.instr = {16'h0000, half};  // Raw halfword with upper part zero
  end
  assign out.item = item;

  ////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    fetch_addr_d = fetch_addr_q;
    held_word_d  = held_word_q;
    held_valid_d = held_valid_q;
    mem.req      = 1'b0;
    mem.addr     = {fetch_addr_q[AW-1:2], 2'b00};
    mem.flush    = 1'b0;
    out.valid    = 1'b0;

    if (branch_i) begin
      // Branch wins in every state and cancels the current item
      held_valid_d = 1'b0;
      fetch_addr_d = branch_addr_i;
      mem.flush    = 1'b1;
      if (req_i) begin
        mem.req  = 1'b1;
        mem.addr = {branch_addr_i[AW-1:2], 2'b00};
        state_d  = mem.gnt ? WAIT_RVALID : WAIT_GNT;
      end else begin
        state_d = IDLE;
      end
    end else begin
      unique case (state_q)
        IDLE: begin
          if (held_valid_q && misaligned) begin
            out.valid = 1'b1;  // High half of the kept word without a memory access
            if (out.ready) begin
              held_valid_d = 1'b0;
              fetch_addr_d = pc_next;
            end
          end else if (req_i) begin
            held_valid_d = 1'b0;
            mem.req      = 1'b1;
            state_d      = mem.gnt ? WAIT_RVALID : WAIT_GNT;
          end
        end

        WAIT_GNT: begin
          mem.req = 1'b1;  // Hold req and addr until granted
          if (mem.gnt)
            state_d = WAIT_RVALID;
        end

        WAIT_RVALID: begin
          if (word_avail) begin
            out.valid   = 1'b1;
            held_word_d = word_mux;
            if (!out.ready) begin
              held_valid_d = 1'b1;  // Stall keeps the word stable
            end else begin
              fetch_addr_d = pc_next;
              if (fmt == fetch_pkg::C_ALIGNED) begin
                held_valid_d = 1'b1;  // High half may be another instruction
                state_d      = IDLE;
              end else begin
                held_valid_d = 1'b0;
                if (req_i) begin
                  // Chain the next fetch without a bubble
                  mem.req  = 1'b1;
                  mem.addr = {pc_next[AW-1:2], 2'b00};
                  state_d  = mem.gnt ? WAIT_RVALID : WAIT_GNT;
                end else begin
                  state_d = IDLE;
                end
              end
            end
          end
        end

        default: state_d = IDLE;
      endcase
    end
  end

  assign busy_o = (state_q != IDLE) | mem.req | out.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      fetch_addr_q <= `FETCH_BOOT_ADDR;
      held_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      fetch_addr_q <= fetch_addr_d;
      held_valid_q <= held_valid_d;
    end
  end

  // Held word storage
  always_ff @(posedge clk) begin
    held_word_q <= held_word_d;
  end

endmodule

/* source/rvc_expander.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module rvc_expander (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     branch_i,
  fetch_out_if.sink                in,
  output logic                     id_valid_o,
  input  logic                     id_ready_i,
  output logic [`FETCH_ADDR_W-1:0] id_instr_o,
  output logic [`FETCH_ADDR_W-1:0] id_addr_o,
  output logic                     id_compressed_o,
  output logic                     id_illegal_o,
  output logic                     id_unsupported_o,
  output logic                     full_o
);
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;

  fetch_pkg::rvc_op_e       op;
  logic [15:0]              c;
  logic [4:0]               rd;
  logic [4:0]               rs2;
  logic [11:0]              imm;
  logic [`FETCH_ADDR_W-1:0] expanded;
  logic                     full_q;
  logic                     load;

  assign c   = in.item.instr[15:0];
  assign rd  = c[11:7];                          // Also rs1 for ADDI and ADD
  assign rs2 = c[6:2];
  assign imm = {{6{c[12]}}, c[12], c[6:2]};      // Sign extended CI immediate

  // Classify by funct3 and quadrant
  always_comb begin
    op = fetch_pkg::RVC_OTHER;
    if (in.item.compressed) begin
      case ({c[15:13], c[1:0]})
        5'b000_01: op = fetch_pkg::RVC_ADDI;   // C.NOP lands here too
        5'b010_01: op = fetch_pkg::RVC_LI;
        5'b100_10: begin
          // rs2 of zero means JR, JALR or EBREAK
          if (rs2 != 5'd0)
            op = c[12] ? fetch_pkg::RVC_ADD : fetch_pkg::RVC_MV;
        end
        default:   op = fetch_pkg::RVC_OTHER;
      endcase
    end
  end

  // 32-bit equivalents
  always_comb begin
    unique case (op)
      fetch_pkg::RVC_ADDI: expanded = {imm, rd, 3'b000, rd, OPC_OPIMM};
      fetch_pkg::RVC_LI:   expanded = {imm, 5'd0, 3'b000, rd, OPC_OPIMM};    // addi rd, x0
      fetch_pkg::RVC_MV:   expanded = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP}; // add rd, x0
      fetch_pkg::RVC_ADD:  expanded = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
      default:             expanded = in.item.instr;                        // Raw
    endcase
  end

  ////////////////////////////////////////
  // Output register toward decode
  ////////////////////////////////////////

  assign in.ready = ~full_q | id_ready_i;   // Refill while decode drains
  assign load     = in.valid & in.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      full_q <= 1'b0;
    else if (branch_i)
      full_q <= 1'b0;                       // Drop the wrong-path item
    else if (load)
      full_q <= 1'b1;
    else if (id_ready_i)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      id_instr_o       <= expanded;
      id_addr_o        <= in.item.pc;
      id_compressed_o  <= in.item.compressed;
      id_illegal_o     <= in.item.illegal;
      id_unsupported_o <= in.item.compressed && (op == fetch_pkg::RVC_OTHER);
    end
  end

  assign id_valid_o = full_q;
  assign full_o     = full_q;

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Controller
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  // Instruction memory
  output logic                     instr_req_o,
  input  logic                     instr_gnt_i,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input  logic [`FETCH_ADDR_W-1:0] instr_rdata_i,
  input  logic                     instr_rvalid_i,
  // Decode
  output logic                     id_valid_o,
  input  logic                     id_ready_i,
  output logic [`FETCH_ADDR_W-1:0] id_instr_o,
  output logic [`FETCH_ADDR_W-1:0] id_addr_o,
  output logic                     id_compressed_o,
  output logic                     id_illegal_o,
  output logic                     id_unsupported_o,
  output logic                     busy_o
);
  logic buf_busy;  // Buffer FSM active or item offered
  logic outst;     // Grants waiting for rvalid
  logic exp_full;  // Output register occupied

  instr_mem_if mem_if ();
  fetch_out_if out_if ();

  fetch_mem_port u_mem_port (
    .clk, .rst_n, .mem(mem_if.slave),
    .instr_req_o, .instr_gnt_i, .instr_addr_o, .instr_rdata_i, .instr_rvalid_i,
    .outst_o(outst)
  );

  prefetch_buffer u_prefetch (
    .clk, .rst_n, .req_i, .branch_i, .branch_addr_i,
    .mem(mem_if.master), .out(out_if.source), .busy_o(buf_busy)
  );

  rvc_expander u_expander (
    .clk, .rst_n, .branch_i, .in(out_if.sink),
    .id_valid_o, .id_ready_i, .id_instr_o, .id_addr_o,
    .id_compressed_o, .id_illegal_o, .id_unsupported_o,
    .full_o(exp_full)
  );

  assign busy_o = buf_busy | outst | exp_full;

endmodule

/* sim/imem_model.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module imem_model #(
  parameter logic [15:0] SEED = 16'd66
) (
  input  logic                     clk,
  input  logic                     req_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  output logic                     gnt_o,
  output logic [`FETCH_ADDR_W-1:0] rdata_o,
  output logic                     rvalid_o
);
  logic [31:0] mem [256];   // 1 KB image, wraps on addr_i[9:2]
  logic [31:0] rsp_q [$];   // Granted words, oldest first
  logic [15:0] lfsr = SEED;
  logic [31:0] grant_addr;
  logic        granted;
  int          gnt_wait;    // Cycles until gnt goes high
  int          rsp_wait;    // Cycles until the head returns

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};                          // One step per bit
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;  // Galois taps
    end
    return v;
  endfunction

  // One compressed encoding, fields taken from the word index
  function automatic logic [15:0] rvc_word(input logic [7:0] i, input logic [2:0] sel);
    logic [4:0] r;
    logic [4:0] r2;
    r  = {i[3:0], 1'b1};  // Never x0
    r2 = {i[7:4], 1'b1};
    case (sel)
      3'd0:    return {3'b000, i[7], r, i[6:2], 2'b01};    // C.ADDI
      3'd1:    return {3'b010, i[6], r, i[5:1], 2'b01};    // C.LI
      3'd2:    return {3'b100, 1'b0, r, r2, 2'b10};        // C.MV
      3'd3:    return {3'b100, 1'b1, r, r2, 2'b10};        // C.ADD
      3'd4:    return 16'h0001;                            // C.NOP
      3'd5:    return {3'b010, 3'b000, i, 2'b00};          // C.LW
      3'd6:    return {3'b101, 3'b000, i, 2'b01};          // C.J
      default: return {3'b100, 1'b0, r, 5'd0, 2'b10};      // C.JR
    endcase
  endfunction

  function automatic logic [31:0] image_word(input logic [7:0] i);
    case (i[4:3] ^ i[6:5])
      2'd0:    return {i, ~i, i ^ 8'h5A, 8'h13};           // Aligned 32-bit op
      2'd1:    return {rvc_word(i, i[2:0] + 3'd3), rvc_word(i, i[2:0])};
      2'd2:    return {i, 8'hB7, rvc_word(i, i[2:0])};     // 32-bit at odd half
      default: return {rvc_word(i, {1'b1, i[1:0]}), rvc_word(i, i[2:0] ^ 3'd5)};
    endcase
  endfunction

  //////////////////////////////////////////
  // Grant and in-order response engine
  //////////////////////////////////////////

  initial begin
    for (int i = 0; i < 256; i++)
      mem[i] = image_word(i[7:0]);
    gnt_o    = 1'b0;
    rdata_o  = '0;
    rvalid_o = 1'b0;
    granted  = 1'b0;
    gnt_wait = 0;
    rsp_wait = 0;
    forever begin
      @(posedge clk);
      #1;
      if (granted) begin
        if (rsp_q.size() == 0)
          rsp_wait = rand_bits(2) % 3;     // 1 to 3 cycles after the grant
        rsp_q.push_back(mem[grant_addr[9:2]]);
        gnt_wait = rand_bits(2);           // 0 to 3 cycles to next grant
      end
      rvalid_o = 1'b0;
      if (rsp_q.size() > 0 && rsp_wait == 0) begin
        rvalid_o = 1'b1;
        rdata_o  = rsp_q.pop_front();
        rsp_wait = rand_bits(2) % 3;
      end else if (rsp_q.size() > 0) begin
        rsp_wait--;
      end
      gnt_o = (gnt_wait == 0);
      if (gnt_wait > 0)
        gnt_wait--;
      @(negedge clk);                      // Pins settled mid-cycle
      granted    = req_i && gnt_o;
      grant_addr = addr_i;
    end
  end

endmodule

/* sim/tb_fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module tb_fetch_top;
  localparam int AW        = `FETCH_ADDR_W;
  localparam int CYC_LIMIT = 20000;  // Per phase

  logic          clk, rst_n, req_i, branch_i, id_ready_i;
  logic [AW-1:0] branch_addr_i;
  logic          instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [AW-1:0] instr_addr_o, instr_rdata_i;
  logic          id_valid_o, id_compressed_o, id_illegal_o, id_unsupported_o, busy_o;
  logic [AW-1:0] id_instr_o, id_addr_o;

  logic [15:0]   lfsr = 16'd66;
  int            checked, errors, timeouts, n_exp, n_unsup, n_ill;
  int            pending;  // Grants at the memory pins still waiting for rvalid

  fetch_top DUT (.*);

  imem_model #(.SEED(16'd66)) u_imem (
    .clk, .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_o(instr_gnt_i), .rdata_o(instr_rdata_i), .rvalid_o(instr_rvalid_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;  // Galois step
    end
    return v;
  endfunction

  // Expected decode item at pc from the image and the RVC rules
  function automatic void ref_fetch(input logic [AW-1:0] pc, output logic [AW-1:0] instr,
                                    output logic comp, output logic ill, output logic unsup,
                                    output logic [AW-1:0] next_pc);
    logic [31:0] word;
    logic [15:0] h;
    logic [11:0] imm;
    word    = u_imem.mem[pc[9:2]];
    h       = pc[1] ? word[31:16] : word[15:0];
    imm     = {{7{h[12]}}, h[6:2]};
    instr   = {16'h0000, h};
    comp    = 1'b0;
    ill     = 1'b0;
    unsup   = 1'b0;
    next_pc = pc + 2;
    if (!pc[1] && word[1:0] == 2'b11) begin
      instr   = word;                                        // Plain 32-bit
      next_pc = pc + 4;
    end else if (h[1:0] == 2'b11) begin
      ill = 1'b1;                                            // 32-bit at odd half
    end else begin
      comp = 1'b1;
      if ({h[15:13], h[1:0]} == 5'b000_01)
        instr = {imm, h[11:7], 3'b000, h[11:7], 7'h13};      // addi rd, rd
      else if ({h[15:13], h[1:0]} == 5'b010_01)
        instr = {imm, 5'd0, 3'b000, h[11:7], 7'h13};         // addi rd, x0
      else if ({h[15:13], h[1:0]} == 5'b100_10 && h[6:2] != 5'd0)
        instr = {7'd0, h[6:2], h[12] ? h[11:7] : 5'd0, 3'b000, h[11:7], 7'h33};
      else
        unsup = 1'b1;
    end
  endfunction

  //////////////////////////////////////////
  // Comparator on the decode handshake
  //////////////////////////////////////////

  initial begin
    logic [AW-1:0]     exp_pc, exp_instr, exp_next;
    logic              exp_c, exp_il, exp_un, prev_wait;
    logic [2*AW+2:0]   prev_out;
    exp_pc    = `FETCH_BOOT_ADDR;
    prev_wait = 1'b0;
    prev_out  = '0;
    forever begin
      @(negedge clk);
      if (prev_wait) begin
        assert (id_valid_o && {id_instr_o, id_addr_o, id_compressed_o, id_illegal_o,
                               id_unsupported_o} == prev_out)
        else begin
          $display("mismatch at %0t: stalled item at pc %h changed or vanished",
                   $time, prev_out[AW+2:3]);
          errors++;
        end
      end
      prev_wait = id_valid_o && !id_ready_i && !branch_i;
      prev_out  = {id_instr_o, id_addr_o, id_compressed_o, id_illegal_o, id_unsupported_o};
      if (branch_i) begin
        exp_pc = branch_addr_i;                              // Wrong path dropped
      end else if (id_valid_o && id_ready_i) begin
        ref_fetch(exp_pc, exp_instr, exp_c, exp_il, exp_un, exp_next);
        assert (id_addr_o == exp_pc && id_instr_o == exp_instr && id_compressed_o == exp_c
                && id_illegal_o == exp_il && id_unsupported_o == exp_un)
        else begin
          $display("mismatch at %0t: pc %h instr %h c%b i%b u%b, expected %h %h c%b i%b u%b",
                   $time, id_addr_o, id_instr_o, id_compressed_o, id_illegal_o,
                   id_unsupported_o, exp_pc, exp_instr, exp_c, exp_il, exp_un);
          errors++;
        end
        checked++;
        n_exp   += (exp_c && !exp_un);
        n_unsup += exp_un;
        n_ill   += exp_il;
        exp_pc   = exp_next;
      end
    end
  end

  // Count requests granted at the memory pins against their responses
  initial begin
    pending = 0;
    forever begin
      @(negedge clk);
      if (instr_req_o && instr_gnt_i)
        pending++;
      if (instr_rvalid_i)
        pending--;
    end
  end

  task automatic check_idle(input string name);
    assert (!id_valid_o && !instr_req_o && !busy_o)
    else begin
      $display("%s: DUT not idle, valid %b req %b busy %b", name, id_valid_o,
               instr_req_o, busy_o);
      errors++;
    end
    $display("%s: idle check done", name);
  endtask

  // Run until enough items pass decode with optional stall and branch noise
  task automatic run_phase(input string name, input int items, input logic bp, input logic br);
    int start, err0, cycles;
    start  = checked;
    err0   = errors;
    cycles = 0;
    while (checked - start < items && cycles < CYC_LIMIT) begin
      @(posedge clk);
      #1;
      req_i      = 1'b1;
      id_ready_i = bp ? (rand_bits(2) != 0) : 1'b1;         // 3 of 4 cycles ready
      branch_i   = br && (rand_bits(5) == 0);
      if (branch_i)
        branch_addr_i = rand_bits(10) & 32'h0000_03FE;       // Any halfword target
      cycles++;
    end
    if (checked - start < items) begin
      $display("timeout: %s phase saw only %0d of %0d items", name, checked - start, items);
      timeouts++;
    end else begin
      $display("%s: %0d items, %0d errors", name, checked - start, errors - err0);
    end
  endtask

  initial begin
    int cycles;
    {checked, errors, timeouts, n_exp, n_unsup, n_ill} = '0;
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    id_ready_i    = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_idle("reset");
    run_phase("stream", 200, 1'b0, 1'b0);
    run_phase("backpressure", 200, 1'b1, 1'b0);
    run_phase("branches", 300, 1'b1, 1'b1);
    assert (n_exp > 0 && n_unsup > 0 && n_ill > 0)
    else begin
      $display("formats: some instruction class never reached decode");
      errors++;
    end
    $display("formats: %0d expanded, %0d unsupported, %0d illegal", n_exp, n_unsup, n_ill);
    // Drop req_i and wait until the memory pins and the decode side go quiet
    @(posedge clk);
    #1;
    req_i      = 1'b0;
    branch_i   = 1'b0;
    id_ready_i = 1'b1;
    cycles     = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while ((id_valid_o || instr_req_o || instr_rvalid_i || pending != 0) && cycles < 200);
    if (id_valid_o || instr_req_o || instr_rvalid_i || pending != 0) begin
      $display("timeout: DUT still fetching long after req_i was dropped");
      timeouts++;
    end else begin
      check_idle("drain");
    end
    $display("checked %0d items, %0d errors, %0d timeouts", checked, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/fetch_pkg.sv
source/fetch_ifs.sv
source/fetch_mem_port.sv
source/prefetch_buffer.sv
source/rvc_expander.sv
source/fetch_top.sv
sim/imem_model.sv
sim/tb_fetch_top.sv

/* Makefile */
SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

all: run

obj_dir/Vtb_fetch_top: src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fetch_top -Mdir obj_dir

run: obj_dir/Vtb_fetch_top
	./obj_dir/Vtb_fetch_top | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
